// ==== verilog.f ====
+incdir+design
design/priv_isa_pkg.sv
design/priv_bus_pkg.sv
design/priv_exec.sv
design/csr_file.sv
design/cache_ctrl.sv
design/priv_unit_top.sv
sim/tb_clk_gen.sv
sim/tb_priv_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the privileged unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_priv_unit -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tb_sim
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit $run_status
fi

exit 0

// ==== sim/tb_priv_unit.sv ====
`include "priv_settings.svh"

module tb_priv_unit;
    timeunit 1ns;
    timeprecision 1ps;

    import priv_isa_pkg::*;

    localparam int CYCLE_LIMIT = 2000;

    logic                   clk;
    logic                   rstn;
    logic                   en;
    ins_t                   ins;
    pr_kind_t               pr_kind;
    word_t                  rj_data;
    word_t                  rk_data;
    logic                   flush;
    logic [`NUM_CACHES-1:0] fill;
    word_t                  fill_addr [`NUM_CACHES];
    word_t                  probe_addr [`NUM_CACHES];
    logic                   done;
    word_t                  rd_data;
    logic                   ertn_valid;
    word_t                  ertn_pc;
    logic                   block_clock;
    logic [`NUM_CACHES-1:0] probe_hit;

    word_t    rng;
    int       cycles;
    word_t    csr_mdl [7];          // crmd, prmd, era, save0..3
    csr_num_t csr_nums [7];
    word_t    line_addr [`NUM_CACHES][`CACHE_LINES];
    logic     valid_mdl [`NUM_CACHES][`CACHE_LINES];

    tb_clk_gen u_clk (.clk(clk));

    priv_unit_top priv_unit_top_inst (
        .clk         (clk),
        .rstn        (rstn),
        .en          (en),
        .ins         (ins),
        .pr_kind     (pr_kind),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .flush       (flush),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .probe_addr  (probe_addr),
        .done        (done),
        .rd_data     (rd_data),
        .ertn_valid  (ertn_valid),
        .ertn_pc     (ertn_pc),
        .block_clock (block_clock),
        .probe_hit   (probe_hit)
    );

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic draw_word(output word_t v);
        rng = xorshift32(rng);
        v = rng;
    endtask

    task automatic mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "check failed");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Run did not finish within %0d cycles, the DUT hung", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // counts cycles until done, sampled mid cycle
    task automatic wait_done(output int n);
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!done);
    endtask

    task automatic issue(input pr_kind_t k, input ins_t i, input word_t rj, input word_t rk,
                         output int n);
        @(posedge clk);
        en      <= 1'b1;
        pr_kind <= k;
        ins     <= i;
        rj_data <= rj;
        rk_data <= rk;
        @(posedge clk);
        en      <= 1'b0;
        pr_kind <= KIND_NONE;
        wait_done(n);
    endtask

    // fld 0 read, 1 write, else masked exchange
    task automatic csr_op(input int slot, input logic [4:0] fld, input word_t rj, input word_t rk);
        word_t old;
        word_t nxt;
        int    n;
        old = csr_mdl[slot];
        if (fld == 5'd0)
            nxt = old;
        else if (fld == 5'd1)
            nxt = rk;
        else
            for (int b = 0; b < 32; b++)
                nxt[b] = rj[b] ? rk[b] : old[b];    // mask bit picks rk
        issue(KIND_CSR, {8'h04, csr_nums[slot], fld, 5'd0}, rj, rk, n);
        assert (n == 1) else mismatch($sformatf("csr done after %0d cycles", n));
        assert (rd_data == old)
        else
            mismatch($sformatf("csr %h rd_data %h exp %h", csr_nums[slot], rd_data, old));
        csr_mdl[slot] = nxt;
    endtask

    task automatic run_ertn();
        int n;
        @(posedge clk);
        en      <= 1'b1;
        pr_kind <= KIND_ERTN;
        ins     <= 32'h0648_3800;
        @(negedge clk);
        assert (ertn_valid && ertn_pc == csr_mdl[2])
        else
            mismatch($sformatf("ertn_pc %h exp %h", ertn_pc, csr_mdl[2]));
        @(posedge clk);
        en      <= 1'b0;
        pr_kind <= KIND_NONE;
        wait_done(n);
        assert (n == 1) else mismatch($sformatf("ertn done after %0d cycles", n));
        csr_mdl[0][`PLV_IE_BITS-1:0] = csr_mdl[1][`PLV_IE_BITS-1:0];
    endtask

    task automatic refill(input int c);
        word_t r;
        for (int l = 0; l < `CACHE_LINES; l++)
        begin
            draw_word(r);
            line_addr[c][l] = (r & ~32'h7f) | (word_t'(l) << `INDEX_LSB);
            valid_mdl[c][l] = 1'b1;
            @(posedge clk);
            fill[c]      <= 1'b1;
            fill_addr[c] <= line_addr[c][l];
        end
        @(posedge clk);
        fill[c] <= 1'b0;
    endtask

    task automatic check_lines(input int c);
        for (int l = 0; l < `CACHE_LINES; l++)
        begin
            @(posedge clk);
            probe_addr[c] <= line_addr[c][l];
            @(negedge clk);
            assert (probe_hit[c] == valid_mdl[c][l])
            else
                mismatch($sformatf("cache %0d line %0d hit %b exp %b",
                                   c, l, probe_hit[c], valid_mdl[c][l]));
        end
    endtask

    function automatic ins_t cacop_ins(input logic [11:0] imm, input cacop_op_t op, input int c);
        return {10'h0, imm, 5'd0, op, 2'b00, c[0]};
    endfunction

    task automatic cacop(input int c, input cacop_op_t op, input word_t target);
        word_t r;
        int    n;
        int    idx;
        draw_word(r);
        idx = int'(target[`INDEX_LSB +: 3]);
        issue(KIND_CACHE, cacop_ins(r[11:0], op, c), target - {{20{r[11]}}, r[11:0]}, '0, n);
        if (op == 2'd0)
            valid_mdl[c][idx] = 1'b0;
        else if (op == 2'd1)
            for (int l = 0; l < `CACHE_LINES; l++)
                valid_mdl[c][l] = 1'b0;
        else if (op == 2'd2 && line_addr[c][idx][31:7] == target[31:7])
            valid_mdl[c][idx] = 1'b0;
        check_lines(c);
    endtask

    // cacop on dcache, flushed mid wait, then idle while the cache still counts down
    task automatic flush_then_idle();
        word_t r;
        int    pulses;
        logic  prev_block;
        draw_word(r);
        probe_addr[1] <= line_addr[1][3];
        @(posedge clk);
        en      <= 1'b1;
        pr_kind <= KIND_CACHE;
        ins     <= cacop_ins(r[11:0], 2'd0, 1);
        rj_data <= line_addr[1][3] - {{20{r[11]}}, r[11:0]};
        @(posedge clk);
        en      <= 1'b0;
        pr_kind <= KIND_NONE;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush   <= 1'b0;
        en      <= 1'b1;
        pr_kind <= KIND_IDLE;
        @(posedge clk);
        en      <= 1'b0;
        pr_kind <= KIND_NONE;
        pulses     = 0;
        prev_block = 1'b0;
        do
        begin
            @(negedge clk);
            if (block_clock)
            begin
                pulses++;
                assert (!probe_hit[1]) else mismatch("block_clock while dcache busy");
            end
            if (done)
            begin
                assert (prev_block && pulses == 1)
                else
                    mismatch($sformatf("idle done with %0d block_clock pulses", pulses));
            end
            prev_block = block_clock;
        end
        while (!done);
        valid_mdl[1][3] = 1'b0;
        check_lines(1);
    endtask

    initial
    begin
        word_t a;
        word_t b;
        rng        = 32'd336;
        cycles     = 0;
        rstn       = 1'b0;
        en         = 1'b0;
        ins        = '0;
        pr_kind    = KIND_NONE;
        rj_data    = '0;
        rk_data    = '0;
        flush      = 1'b0;
        fill       = '0;
        fill_addr  = '{default: '0};
        probe_addr = '{default: '0};
        csr_nums   = '{CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};
        csr_mdl    = '{default: '0};
        csr_mdl[0] = `CRMD_RESET;
        for (int c = 0; c < `NUM_CACHES; c++)
            for (int l = 0; l < `CACHE_LINES; l++)
            begin
                valid_mdl[c][l] = 1'b0;
                line_addr[c][l] = '0;
            end

        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!done && !ertn_valid && !block_clock && probe_hit == '0)
        else
            mismatch("outputs not cleared by reset");

        for (int s = 1; s < 7; s++)
        begin
            draw_word(a);
            draw_word(b);
            csr_op(s, 5'd1, a, b);
        end
        for (int s = 0; s < 7; s++)
            csr_op(s, 5'd0, '0, '0);

        for (int s = 3; s < 7; s++)
        begin
            draw_word(a);
            draw_word(b);
            csr_op(s, a[4:0] | 5'd2, a, b);
            csr_op(s, 5'd0, '0, '0);
        end

        draw_word(a);
        draw_word(b);
        csr_op(1, 5'd1, '0, a | 32'h7);     // plv 3 and ie set in prmd
        csr_op(2, 5'd1, '0, b);
        run_ertn();
        csr_op(0, 5'd0, '0, '0);

        for (int c = 0; c < `NUM_CACHES; c++)
        begin
            refill(c);
            check_lines(c);
            cacop(c, 2'd3, line_addr[c][1]);
            cacop(c, 2'd0, line_addr[c][2] ^ 32'h4000_0000);
            cacop(c, 2'd2, line_addr[c][5] ^ 32'h8000_0000);
            cacop(c, 2'd2, line_addr[c][5]);
            cacop(c, 2'd1, line_addr[c][0]);
        end

        refill(1);
        flush_then_idle();
        draw_word(a);
        csr_op(3, 5'd1, '0, a);
        csr_op(3, 5'd0, '0, '0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 20ns;     // 40 ns clock

    initial
        clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== design/priv_unit_top.sv ====
`include "priv_settings.svh"

module priv_unit_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     en,
    input  priv_isa_pkg::ins_t       ins,
    input  priv_isa_pkg::pr_kind_t   pr_kind,
    input  priv_isa_pkg::word_t      rj_data,
    input  priv_isa_pkg::word_t      rk_data,
    input  logic                     flush,
    input  logic [`NUM_CACHES-1:0]   fill,
    input  priv_isa_pkg::word_t      fill_addr [`NUM_CACHES],
    input  priv_isa_pkg::word_t      probe_addr [`NUM_CACHES],
    output logic                     done,
    output priv_isa_pkg::word_t      rd_data,
    output logic                     ertn_valid,
    output priv_isa_pkg::word_t      ertn_pc,
    output logic                     block_clock,
    output logic [`NUM_CACHES-1:0]   probe_hit
);
    import priv_isa_pkg::*;
    import priv_bus_pkg::*;

    csr_req_t               csr_req;
    word_t                  csr_rdata;
    cacop_req_t             cacop_req;
    logic [`NUM_CACHES-1:0] cache_en;
    logic [`NUM_CACHES-1:0] cache_ready;
    logic [`NUM_CACHES-1:0] cache_done;
    logic [`NUM_CACHES-1:0] cache_idle;

    priv_exec u_exec (
        .clk         (clk),
        .rstn        (rstn),
        .en          (en),
        .flush       (flush),
        .ins         (ins),
        .pr_kind     (pr_kind),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .csr_rdata   (csr_rdata),
        .cache_ready (cache_ready),
        .cache_done  (cache_done),
        .cache_idle  (cache_idle),
        .csr_req     (csr_req),
        .cacop_req   (cacop_req),
        .cache_en    (cache_en),
        .ertn        (ertn_valid),
        .block_clock (block_clock),
        .done        (done),
        .rd_data     (rd_data)
    );

    csr_file u_csr (
        .clk       (clk),
        .rstn      (rstn),
        .csr_req   (csr_req),
        .ertn      (ertn_valid),
        .csr_rdata (csr_rdata),
        .ertn_pc   (ertn_pc)
    );

    // index 0 icache, index 1 dcache
    for (genvar g = 0; g < `NUM_CACHES; g++)
    begin : g_cache
        cache_ctrl u_cache (
            .clk        (clk),
            .rstn       (rstn),
            .cacop_en   (cache_en[g]),
            .cacop_req  (cacop_req),
            .fill       (fill[g]),
            .fill_addr  (fill_addr[g]),
            .probe_addr (probe_addr[g]),
            .ready      (cache_ready[g]),
            .done       (cache_done[g]),
            .idle       (cache_idle[g]),
            .probe_hit  (probe_hit[g])
        );
    end

endmodule

// ==== design/cache_ctrl.sv ====
`include "priv_settings.svh"

module cache_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cacop_en,
    input  priv_bus_pkg::cacop_req_t  cacop_req,
    input  logic                      fill,
    input  priv_isa_pkg::word_t       fill_addr,
    input  priv_isa_pkg::word_t       probe_addr,
    output logic                      ready,
    output logic                      done,
    output logic                      idle,
    output logic                      probe_hit
);
    import priv_isa_pkg::*;
    import priv_bus_pkg::*;

    localparam int IDX_W   = $clog2(`CACHE_LINES);
    localparam int TAG_LSB = `INDEX_LSB + IDX_W;
    localparam int CNT_W   = $clog2(`CACOP_LATENCY + 1);

    typedef logic [IDX_W-1:0]      idx_t;
    typedef logic [31-TAG_LSB:0]   tag_t;
    typedef logic [CNT_W-1:0]      cnt_t;

    function automatic idx_t idx_of(input word_t a);
        return a[`INDEX_LSB +: IDX_W];
    endfunction

    function automatic tag_t tag_of(input word_t a);
        return a[31:TAG_LSB];
    endfunction

    tag_t                    tag_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    cnt_t                    busy_q;
    cacop_req_t              req_q;
    idx_t                    op_idx;
    idx_t                    probe_idx;
    logic                    op_hit;

    assign ready = (busy_q == '0);
    assign done  = (busy_q == cnt_t'(1));
    assign idle  = ready && !cacop_en;     // nothing pending or in flight

    assign op_idx    = idx_of(req_q.vaddr);
    assign op_hit    = (tag_q[op_idx] == tag_of(req_q.vaddr));
    assign probe_idx = idx_of(probe_addr);
    assign probe_hit = valid_q[probe_idx] && (tag_q[probe_idx] == tag_of(probe_addr));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            busy_q <= '0;
        else if (cacop_en && ready)
            busy_q <= cnt_t'(`CACOP_LATENCY);
        else if (!ready)
            busy_q <= busy_q - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (cacop_en && ready)
            req_q <= cacop_req;
        if (fill)
            tag_q[idx_of(fill_addr)] <= tag_of(fill_addr);
    end

    // invalidation lands on the done cycle and wins over a fill
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            valid_q <= '0;
        else
        begin
            if (fill)
                valid_q[idx_of(fill_addr)] <= 1'b1;
            if (done)
            begin
                case (req_q.op)
                    CACOP_IDX_INV: valid_q[op_idx] <= 1'b0;
                    CACOP_ALL_INV: valid_q <= '0;
                    CACOP_HIT_INV:
                    begin
                        if (op_hit)
                            valid_q[op_idx] <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/csr_file.sv ====
`include "priv_settings.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    rstn,
    input  priv_bus_pkg::csr_req_t  csr_req,
    input  logic                    ertn,
    output priv_isa_pkg::word_t     csr_rdata,
    output priv_isa_pkg::word_t     ertn_pc
);
    import priv_isa_pkg::*;

    word_t crmd_q;
    word_t prmd_q;
    word_t era_q;
    word_t save_q [`CSR_SAVE_NUM];

    assign ertn_pc = era_q;

    always_comb
    begin
        csr_rdata = '0;
        if (csr_req.re)
        begin
            case (csr_req.addr)
                CSR_CRMD:  csr_rdata = crmd_q;
                CSR_PRMD:  csr_rdata = prmd_q;
                CSR_ERA:   csr_rdata = era_q;
                CSR_SAVE0: csr_rdata = save_q[0];
                CSR_SAVE1: csr_rdata = save_q[1];
                CSR_SAVE2: csr_rdata = save_q[2];
                CSR_SAVE3: csr_rdata = save_q[3];
                default:   csr_rdata = '0;      // unimplemented csr
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd_q <= `CRMD_RESET;
            prmd_q <= '0;
            era_q  <= '0;
            for (int i = 0; i < `CSR_SAVE_NUM; i++)
                save_q[i] <= '0;
        end
        else if (ertn)
            crmd_q[`PLV_IE_BITS-1:0] <= prmd_q[`PLV_IE_BITS-1:0];   // restore plv, ie
        else if (csr_req.we)
        begin
            case (csr_req.addr)
                CSR_CRMD:  crmd_q    <= csr_req.wdata;
                CSR_PRMD:  prmd_q    <= csr_req.wdata;
                CSR_ERA:   era_q     <= csr_req.wdata;
                CSR_SAVE0: save_q[0] <= csr_req.wdata;
                CSR_SAVE1: save_q[1] <= csr_req.wdata;
                CSR_SAVE2: save_q[2] <= csr_req.wdata;
                CSR_SAVE3: save_q[3] <= csr_req.wdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/priv_exec.sv ====
`include "priv_settings.svh"

module priv_exec (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      en,
    input  logic                      flush,
    input  priv_isa_pkg::ins_t        ins,
    input  priv_isa_pkg::pr_kind_t    pr_kind,
    input  priv_isa_pkg::word_t       rj_data,
    input  priv_isa_pkg::word_t       rk_data,
    input  priv_isa_pkg::word_t       csr_rdata,
    input  logic [`NUM_CACHES-1:0]    cache_ready,
    input  logic [`NUM_CACHES-1:0]    cache_done,
    input  logic [`NUM_CACHES-1:0]    cache_idle,
    output priv_bus_pkg::csr_req_t    csr_req,
    output priv_bus_pkg::cacop_req_t  cacop_req,
    output logic [`NUM_CACHES-1:0]    cache_en,
    output logic                      ertn,
    output logic                      block_clock,
    output logic                      done,
    output priv_isa_pkg::word_t       rd_data
);
    import priv_isa_pkg::*;
    import priv_bus_pkg::*;

    typedef logic [`NUM_CACHES-1:0] cache_vec_t;

    pr_state_t state_q;
    pr_state_t state_d;
    ins_t      ins_q;
    word_t     rj_q;
    word_t     rk_q;
    reg_idx_t  rj_fld;
    imm12_t    imm;
    logic      take;
    logic      csr_go;
    logic      sel_q;
    logic      done_d;

    assign take   = (state_q == S_INIT) && en;
    assign csr_go = take && (pr_kind == KIND_CSR) && cache_idle[`DCACHE_SEL];
    assign rj_fld = ins_q[9:5];
    assign imm    = ins_q[21:10];
    assign sel_q  = ins_q[0];       // 0 icache, 1 dcache

    assign ertn        = take && (pr_kind == KIND_ERTN);
    assign block_clock = (state_q == S_IDLE);

    assign cacop_req.op    = ins_q[4:3];
    assign cacop_req.vaddr = rj_q + {{20{imm[11]}}, imm};

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_INIT:
            begin
                if (csr_go)
                    state_d = S_CSR;
                else if (take && pr_kind == KIND_CACHE)
                    state_d = S_CACOP_CALL;
                else if (take && pr_kind == KIND_ERTN)
                    state_d = S_ERTN;
                else if (take && pr_kind == KIND_IDLE)
                    state_d = S_IDLE_WAIT;
            end
            S_CACOP_CALL:
            begin
                if (cache_ready[sel_q])
                    state_d = S_CACOP_WAIT;
            end
            S_CACOP_WAIT:
            begin
                if (cache_done[sel_q])
                    state_d = S_CACOP_DONE;
            end
            S_IDLE_WAIT:
            begin
                if (&cache_idle)
                    state_d = S_IDLE;
            end
            default:
                state_d = S_INIT;   // CSR, CACOP_DONE, ERTN, IDLE last one cycle
        endcase
    end

    // read in the accept cycle, write back one cycle later
    always_comb
    begin
        csr_req = '0;
        if (state_q == S_CSR)
        begin
            csr_req.addr = ins_q[23:10];
            csr_req.we   = (rj_fld != '0);
            if (rj_fld > reg_idx_t'(1))
                csr_req.wdata = (rd_data & ~rj_q) | (rk_q & rj_q);   // xchg under mask
            else
                csr_req.wdata = rk_q;
        end
        else if (csr_go)
        begin
            csr_req.addr = ins[23:10];
            csr_req.re   = 1'b1;
        end
    end

    assign done_d = csr_go || ertn || (state_q == S_IDLE) ||
                    ((state_q == S_CACOP_WAIT) && cache_done[sel_q]);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q  <= S_INIT;
            done     <= 1'b0;
            cache_en <= '0;
        end
        else if (flush)
        begin
            state_q  <= S_INIT;
            done     <= 1'b0;
            cache_en <= '0;
        end
        else
        begin
            state_q <= state_d;
            done    <= done_d;
            if (take && pr_kind == KIND_CACHE)
                cache_en <= cache_vec_t'(1) << ins[0];
            else if (state_q == S_CACOP_CALL && cache_ready[sel_q])
                cache_en <= '0;     // accepted this cycle
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            ins_q <= ins;
            rj_q  <= rj_data;
            rk_q  <= rk_data;
        end
        if (csr_go)
            rd_data <= csr_rdata;   // old value
    end

endmodule

// ==== design/priv_bus_pkg.sv ====
package priv_bus_pkg;

    // priv_exec to csr_file
    typedef struct packed
    {
        priv_isa_pkg::csr_num_t addr;
        priv_isa_pkg::word_t    wdata;
        logic                   we;
        logic                   re;
    } csr_req_t;

    // priv_exec to every cache_ctrl
    typedef struct packed
    {
        priv_isa_pkg::cacop_op_t op;
        priv_isa_pkg::word_t     vaddr;
    } cacop_req_t;

    typedef enum logic [2:0]
    {
        S_INIT,
        S_CSR,
        S_CACOP_CALL,
        S_CACOP_WAIT,
        S_CACOP_DONE,
        S_ERTN,
        S_IDLE_WAIT,
        S_IDLE
    } pr_state_t;

endpackage

// ==== design/priv_isa_pkg.sv ====
package priv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] ins_t;
    typedef logic [13:0] csr_num_t;     // ins[23:10]
    typedef logic [4:0]  reg_idx_t;     // ins[9:5]
    typedef logic [11:0] imm12_t;       // ins[21:10]
    typedef logic [1:0]  cacop_op_t;    // ins[4:3]

    // decoded micro-op kind from the front end
    typedef enum logic [2:0]
    {
        KIND_NONE,
        KIND_CSR,
        KIND_CACHE,
        KIND_ERTN,
        KIND_IDLE
    } pr_kind_t;

    localparam csr_num_t CSR_CRMD  = 14'h000;
    localparam csr_num_t CSR_PRMD  = 14'h001;
    localparam csr_num_t CSR_ERA   = 14'h006;
    localparam csr_num_t CSR_SAVE0 = 14'h030;
    localparam csr_num_t CSR_SAVE1 = 14'h031;
    localparam csr_num_t CSR_SAVE2 = 14'h032;
    localparam csr_num_t CSR_SAVE3 = 14'h033;

    localparam cacop_op_t CACOP_IDX_INV = 2'd0;
    localparam cacop_op_t CACOP_ALL_INV = 2'd1;
    localparam cacop_op_t CACOP_HIT_INV = 2'd2;   // op 3 does nothing

endpackage

// ==== design/priv_settings.svh ====
`ifndef PRIV_SETTINGS_SVH
`define PRIV_SETTINGS_SVH

// cache controllers
`define CACHE_LINES     8
`define INDEX_LSB       4
`define CACOP_LATENCY   3               // acceptance to done, in cycles
`define NUM_CACHES      2
`define DCACHE_SEL      1               // cache 0 is icache, cache 1 is dcache

// csr file
`define CSR_SAVE_NUM    4
`define PLV_IE_BITS     3               // PLV[1:0] and IE
`define CRMD_RESET      32'h0000_0008   // DA set, PLV0, IE off

`endif
